/* logic/ddr_geom_pkg.sv */
`default_nettype none

package ddr_geom_pkg;

    // DDR4 address map
    localparam int ROW_BITS        = 16;
    localparam int COL_BITS        = 10;
    localparam int BG_BITS         = 2;
    localparam int BA_BITS         = 2;

    localparam int NUM_GROUPS      = 4;
    localparam int BANKS_PER_GROUP = 4;
    localparam int NUM_BANKS       = NUM_GROUPS * BANKS_PER_GROUP;

    localparam int HOST_ADDR_BITS  = ROW_BITS + BG_BITS + BA_BITS + COL_BITS;

    // flat bank number is {bg, ba}
    typedef struct packed {
        logic [BG_BITS-1:0] bg;
        logic [BA_BITS-1:0] ba;
    } ddr_bank_t;

    // host address fields, msb first
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [BG_BITS-1:0]  bg;
        logic [BA_BITS-1:0]  ba;
        logic [COL_BITS-1:0] col;
    } ddr_addr_fields_t;

    // host drives the flat word, the queue array reads the fields
    typedef union packed {
        logic [HOST_ADDR_BITS-1:0] flat;
        ddr_addr_fields_t          f;
    } ddr_host_addr_u;

endpackage

`default_nettype wire

/* logic/ddr_req_pkg.sv */
`default_nettype none

package ddr_req_pkg;

    import ddr_geom_pkg::*;

    localparam int INDEX_BITS = 7;
    localparam int DATA_BITS  = 16;

    // one queued request
    typedef struct packed {
        logic                  is_write;
        logic [ROW_BITS-1:0]   row;
        logic [COL_BITS-1:0]   col;
        logic [DATA_BITS-1:0]  data;
        logic [INDEX_BITS-1:0] idx;
    } ddr_req_t;

    // request picked by the data path, with its bank
    typedef struct packed {
        ddr_req_t  req;
        ddr_bank_t bank;
    } ddr_sel_t;

    // issued command
    typedef struct packed {
        ddr_sel_t sel;
        logic     needs_act;
    } ddr_cmd_t;

endpackage

`default_nettype wire

/* logic/bank_queue_array.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_queue_array
    import ddr_geom_pkg::*;
    import ddr_req_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                            clk_i,
    input  wire                            rst_n_i,
    input  wire                            req_valid_i,
    input  wire                            req_write_i,
    input  wire ddr_host_addr_u            req_addr_i,
    input  wire        [DATA_BITS-1:0]     req_data_i,
    input  wire        [INDEX_BITS-1:0]    req_idx_i,
    input  wire        [NUM_BANKS-1:0]     pop_i,
    output wire ddr_req_t [NUM_BANKS-1:0]  head_o,
    output wire        [NUM_BANKS-1:0]     not_empty_o,
    output logic                           drop_o
);

    localparam int PTR_BITS  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_BITS  = $clog2(QUEUE_DEPTH + 1);
    localparam int BANK_BITS = BG_BITS + BA_BITS;

    localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(QUEUE_DEPTH);
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(QUEUE_DEPTH - 1);

    ddr_bank_t             in_bank;
    logic [BANK_BITS-1:0]  in_bank_num;
    ddr_req_t              in_req;
    wire  [NUM_BANKS-1:0]  full;

    // wraps at any depth, not only powers of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        ptr_inc = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign in_bank     = '{bg: req_addr_i.f.bg, ba: req_addr_i.f.ba};
    assign in_bank_num = in_bank;
    assign in_req      = '{is_write: req_write_i,
                           row:      req_addr_i.f.row,
                           col:      req_addr_i.f.col,
                           data:     req_data_i,
                           idx:      req_idx_i};

    // full test sees the count before this edge's pop
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            drop_o <= 1'b0;
        end else begin
            drop_o <= req_valid_i && full[in_bank_num];
        end
    end

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        ddr_req_t              mem [QUEUE_DEPTH];
        logic [PTR_BITS-1:0]   rd_ptr;
        logic [PTR_BITS-1:0]   wr_ptr;
        logic [CNT_BITS-1:0]   count;
        logic                  push;
        logic                  pop;

        assign push = req_valid_i && (in_bank_num == BANK_BITS'(b)) && !full[b];
        assign pop  = pop_i[b];

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (pop) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk_i) begin
            if (push) begin
                mem[wr_ptr] <= in_req;
            end
        end

        assign full[b]        = (count == FULL_CNT);
        assign not_empty_o[b] = (count != '0);
        assign head_o[b]      = mem[rd_ptr];
    end

    // pops come from the scheduler
    a_pop_not_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pop_i & ~not_empty_o) == '0)
        else $error("pop of an empty bank queue, pop_i=%h", pop_i);

    a_pop_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(pop_i))
        else $error("more than one bank popped, pop_i=%h", pop_i);

endmodule

`default_nettype wire

/* logic/bank_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module bank_scheduler
    import ddr_geom_pkg::*;
(
    input  wire                              clk_i,
    input  wire                              rst_n_i,
    input  wire  [NUM_BANKS-1:0]             not_empty_i,
    output logic [BA_BITS*NUM_GROUPS-1:0]    bank_sel_o,
    output logic [BG_BITS-1:0]               group_sel_o,
    output logic                             issue_o,
    output logic [NUM_BANKS-1:0]             pop_o
);

    // last served group, and last served bank per group
    logic [BG_BITS-1:0]                   grp_ptr;
    logic [NUM_GROUPS-1:0][BA_BITS-1:0]   bank_ptr;

    logic [NUM_GROUPS-1:0]                grp_ne;
    logic [BA_BITS-1:0]                   win_bank;

    // first requester after last, searching upward with wrap.
    // groups and banks are both four wide, so one picker serves both levels
    function automatic logic [1:0] rr_pick(
        input logic [3:0] req,
        input logic [1:0] last
    );
        logic [1:0] cand;
        logic       found;
        rr_pick = last;
        found   = 1'b0;
        for (int off = 1; off <= 4; off++) begin
            cand = last + 2'(off);
            if (!found && req[cand]) begin
                rr_pick = cand;
                found   = 1'b1;
            end
        end
    endfunction

    always_comb begin
        // every group gets its own select, as the data path expects
        for (int g = 0; g < NUM_GROUPS; g++) begin
            grp_ne[g] = |not_empty_i[g*BANKS_PER_GROUP +: BANKS_PER_GROUP];
            bank_sel_o[g*BA_BITS +: BA_BITS] =
                rr_pick(not_empty_i[g*BANKS_PER_GROUP +: BANKS_PER_GROUP], bank_ptr[g]);
        end

        group_sel_o = rr_pick(grp_ne, grp_ptr);
        win_bank    = bank_sel_o[group_sel_o*BA_BITS +: BA_BITS];
        issue_o     = |not_empty_i;

        pop_o = '0;
        if (issue_o) begin
            pop_o[{group_sel_o, win_bank}] = 1'b1;
        end
    end

    // pointers start at 3 so bank 0 of group 0 wins first
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grp_ptr  <= '1;
            bank_ptr <= '1;
        end else if (issue_o) begin
            grp_ptr               <= group_sel_o;
            bank_ptr[group_sel_o] <= win_bank;
        end
    end

    a_pop_hits_queue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_o |-> (pop_o & not_empty_i) != '0)
        else $error("issue popped empty bank, pop_o=%h not_empty=%h", pop_o, not_empty_i);

endmodule

`default_nettype wire

/* logic/data_path.sv */
`timescale 1ns/1ps
`default_nettype none

module data_path
    import ddr_geom_pkg::*;
    import ddr_req_pkg::*;
(
    input  wire ddr_req_t [NUM_BANKS-1:0]     head_i,
    input  wire [BA_BITS*NUM_GROUPS-1:0]      bank_sel_i,
    input  wire [BG_BITS-1:0]                 group_sel_i,
    output ddr_sel_t                          sel_o
);

    // winner of each group, with its bank address
    ddr_req_t [NUM_GROUPS-1:0]                grp_req;
    logic     [NUM_GROUPS-1:0][BA_BITS-1:0]   grp_ba;

    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            case (bank_sel_i[g*BA_BITS +: BA_BITS])
                2'd0: begin
                    grp_req[g] = head_i[g*BANKS_PER_GROUP + 0];
                    grp_ba[g]  = 2'd0;
                end
                2'd1: begin
                    grp_req[g] = head_i[g*BANKS_PER_GROUP + 1];
                    grp_ba[g]  = 2'd1;
                end
                2'd2: begin
                    grp_req[g] = head_i[g*BANKS_PER_GROUP + 2];
                    grp_ba[g]  = 2'd2;
                end
                default: begin
                    grp_req[g] = head_i[g*BANKS_PER_GROUP + 3];
                    grp_ba[g]  = 2'd3;
                end
            endcase
        end
    end

    // second level picks among groups
    always_comb begin
        case (group_sel_i)
            2'd0: begin
                sel_o.req  = grp_req[0];
                sel_o.bank = '{bg: 2'd0, ba: grp_ba[0]};
            end
            2'd1: begin
                sel_o.req  = grp_req[1];
                sel_o.bank = '{bg: 2'd1, ba: grp_ba[1]};
            end
            2'd2: begin
                sel_o.req  = grp_req[2];
                sel_o.bank = '{bg: 2'd2, ba: grp_ba[2]};
            end
            default: begin
                sel_o.req  = grp_req[3];
                sel_o.bank = '{bg: 2'd3, ba: grp_ba[3]};
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/cmd_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_output_stage
    import ddr_geom_pkg::*;
    import ddr_req_pkg::*;
(
    input  wire            clk_i,
    input  wire            rst_n_i,
    input  wire            issue_i,
    input  wire ddr_sel_t  sel_i,
    output logic           cmd_valid_o,
    output ddr_cmd_t       cmd_o
);

    localparam int BANK_BITS = BG_BITS + BA_BITS;

    // open row per bank
    logic [ROW_BITS-1:0]   open_row [NUM_BANKS];
    logic [NUM_BANKS-1:0]  open_vld;

    logic [BANK_BITS-1:0]  bank_num;
    logic                  row_hit;
    logic                  needs_act;

    assign bank_num  = sel_i.bank;
    assign row_hit   = open_vld[bank_num] && (open_row[bank_num] == sel_i.req.row);
    // closed bank or a different row both need an activate
    assign needs_act = !row_hit;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cmd_valid_o <= 1'b0;
            open_vld    <= '0;
        end else begin
            cmd_valid_o <= issue_i;
            if (issue_i) begin
                open_vld[bank_num] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_i) begin
            cmd_o              <= '{sel: sel_i, needs_act: needs_act};
            open_row[bank_num] <= sel_i.req.row;
        end
    end

    // the picked request must be fully known when it is issued
    a_sel_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_i |-> !$isunknown(sel_i))
        else $error("issued request has unknown bits, sel_i=%h", sel_i);

endmodule

`default_nettype wire

/* logic/ddr_sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr_sched_top
    import ddr_geom_pkg::*;
    import ddr_req_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        req_valid_i,
    input  wire                        req_write_i,
    input  wire ddr_host_addr_u        req_addr_i,
    input  wire [DATA_BITS-1:0]        req_data_i,
    input  wire [INDEX_BITS-1:0]       req_idx_i,
    output wire                        drop_o,
    output wire                        cmd_valid_o,
    output wire ddr_cmd_t              cmd_o
);

    ddr_req_t [NUM_BANKS-1:0]          head;
    logic     [NUM_BANKS-1:0]          not_empty;
    logic     [BA_BITS*NUM_GROUPS-1:0] bank_sel;
    logic     [BG_BITS-1:0]            group_sel;
    logic                              issue;
    logic     [NUM_BANKS-1:0]          pop;
    ddr_sel_t                          sel;

    bank_queue_array #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queues (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_idx_i   (req_idx_i),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .drop_o      (drop_o)
    );

    bank_scheduler u_sched (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .not_empty_i (not_empty),
        .bank_sel_o  (bank_sel),
        .group_sel_o (group_sel),
        .issue_o     (issue),
        .pop_o       (pop)
    );

    data_path u_dp (
        .head_i      (head),
        .bank_sel_i  (bank_sel),
        .group_sel_i (group_sel),
        .sel_o       (sel)
    );

    cmd_output_stage u_out (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .issue_i     (issue),
        .sel_i       (sel),
        .cmd_valid_o (cmd_valid_o),
        .cmd_o       (cmd_o)
    );

endmodule

`default_nettype wire

/* tb/sched_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_checker
    import ddr_geom_pkg::*;
    import ddr_req_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire                         req_valid_i,
    input  wire                         req_write_i,
    input  wire ddr_host_addr_u         req_addr_i,
    input  wire [DATA_BITS-1:0]         req_data_i,
    input  wire [INDEX_BITS-1:0]        req_idx_i,
    input  wire                         drop_i,
    input  wire                         cmd_valid_i,
    input  wire ddr_cmd_t               cmd_i,
    output int                          err_cnt_o,
    output int                          accepted_o,
    output int                          issued_o,
    output int                          dropped_o
);

    ddr_req_t            q [NUM_BANKS][$];
    int                  g_ptr;
    int                  b_ptr [NUM_GROUPS];
    logic [ROW_BITS-1:0] open_row [NUM_BANKS];
    logic                open_ok [NUM_BANKS];
    logic                exp_valid;
    logic                exp_drop;
    ddr_cmd_t            exp_cmd;
    int                  errs = 0;
    int                  accepted = 0;
    int                  issued = 0;
    int                  dropped = 0;

    assign err_cnt_o  = errs;
    assign accepted_o = accepted;
    assign issued_o   = issued;
    assign dropped_o  = dropped;

    // one clock edge of the design: issue from the old queue state, then push
    task automatic model_step();
        int                  in_bank;
        logic [ROW_BITS-1:0] in_row;
        logic [COL_BITS-1:0] in_col;
        logic                in_full;
        logic                found;
        logic                busy;
        int                  g;
        int                  cg;
        int                  cb;
        int                  bank;
        ddr_req_t            head;
        // address map from the top bit down is row, bank group, bank, column
        in_col  = req_addr_i.flat[COL_BITS-1:0];
        in_bank = int'(req_addr_i.flat[COL_BITS +: BG_BITS + BA_BITS]);
        in_row  = req_addr_i.flat[COL_BITS + BG_BITS + BA_BITS +: ROW_BITS];
        in_full = (q[in_bank].size() >= QUEUE_DEPTH);
        found   = 1'b0;
        cg      = 0;
        cb      = 0;
        for (int k = 1; k <= NUM_GROUPS; k++) begin
            g    = (g_ptr + k) % NUM_GROUPS;
            busy = 1'b0;
            for (int j = 0; j < BANKS_PER_GROUP; j++) begin
                busy |= (q[g * BANKS_PER_GROUP + j].size() != 0);
            end
            if (!found && busy) begin
                cg    = g;
                found = 1'b1;
            end
        end
        exp_valid = found;
        if (found) begin
            found = 1'b0;
            for (int k = 1; k <= BANKS_PER_GROUP; k++) begin
                bank = cg * BANKS_PER_GROUP + (b_ptr[cg] + k) % BANKS_PER_GROUP;
                if (!found && q[bank].size() != 0) begin
                    cb    = (b_ptr[cg] + k) % BANKS_PER_GROUP;
                    found = 1'b1;
                end
            end
            bank                = cg * BANKS_PER_GROUP + cb;
            head                = q[bank].pop_front();
            exp_cmd.sel.req     = head;
            exp_cmd.sel.bank.bg = BG_BITS'(cg);
            exp_cmd.sel.bank.ba = BA_BITS'(cb);
            exp_cmd.needs_act   = !(open_ok[bank] && open_row[bank] == head.row);
            open_ok[bank]       = 1'b1;
            open_row[bank]      = head.row;
            g_ptr               = cg;
            b_ptr[cg]           = cb;
            issued++;
        end
        exp_drop = req_valid_i && in_full;
        if (req_valid_i && !in_full) begin
            q[in_bank].push_back('{is_write: req_write_i, row: in_row,
                                   col: in_col, data: req_data_i, idx: req_idx_i});
            accepted++;
        end
        if (exp_drop) begin
            dropped++;
        end
    endtask

    always @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                q[b].delete();
                open_ok[b] = 1'b0;
            end
            for (int g = 0; g < NUM_GROUPS; g++) begin
                b_ptr[g] = BANKS_PER_GROUP - 1;
            end
            g_ptr     = NUM_GROUPS - 1;
            exp_valid = 1'b0;
            exp_drop  = 1'b0;
        end else begin
            model_step();
        end
    end

    // outputs settle between edges
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (cmd_valid_i !== exp_valid) begin
                errs++;
                $display("ERR %0t cmd_valid_o expected %b got %b", $time, exp_valid, cmd_valid_i);
            end else if (exp_valid && cmd_i !== exp_cmd) begin
                errs++;
                $display("ERR %0t cmd_o expected %h got %h", $time, exp_cmd, cmd_i);
            end
            if (drop_i !== exp_drop) begin
                errs++;
                $display("ERR %0t drop_o expected %b got %b", $time, exp_drop, drop_i);
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_ddr_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_sched
    import ddr_geom_pkg::*;
    import ddr_req_pkg::*;
();

    localparam int QUEUE_DEPTH = 4;
    localparam int RST_CYCLES  = 5;
    localparam int STIM_CYCLES = RST_CYCLES + 200 + 4 + 32 + 3 * QUEUE_DEPTH + 40 + 300;
    localparam int LIMIT       = STIM_CYCLES + 16 * QUEUE_DEPTH + 100;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_write;
    ddr_host_addr_u        req_addr;
    logic [DATA_BITS-1:0]  req_data;
    logic [INDEX_BITS-1:0] req_idx;
    logic [INDEX_BITS-1:0] next_idx;
    logic [15:0]           lfsr;
    wire                   drop;
    wire                   cmd_valid;
    wire ddr_cmd_t         cmd;
    int                    chk_errs;
    int                    accepted;
    int                    issued;
    int                    dropped;
    int                    tb_errs = 0;
    int                    err_mark = 0;
    int                    tests = 0;
    int                    failed = 0;
    int                    sent = 0;
    int                    cmd_seen = 0;
    int                    cycles = 0;

    ddr_sched_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (
        .clk_i(clk), .rst_n_i(rst_n), .req_valid_i(req_valid), .req_write_i(req_write),
        .req_addr_i(req_addr), .req_data_i(req_data), .req_idx_i(req_idx),
        .drop_o(drop), .cmd_valid_o(cmd_valid), .cmd_o(cmd)
    );

    sched_checker #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_checker (
        .clk_i(clk), .rst_n_i(rst_n), .req_valid_i(req_valid), .req_write_i(req_write),
        .req_addr_i(req_addr), .req_data_i(req_data), .req_idx_i(req_idx),
        .drop_i(drop), .cmd_valid_i(cmd_valid), .cmd_i(cmd), .err_cnt_o(chk_errs),
        .accepted_o(accepted), .issued_o(issued), .dropped_o(dropped)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // commands seen on the DUT output, counted as each cycle closes
    always @(posedge clk) begin
        if (rst_n && cmd_valid === 1'b1) begin
            cmd_seen++;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[15];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // bank < 0 picks a random bank, idle_bits set the request rate
    task automatic drive_cycle(input int bank, input int row_bits, input int idle_bits);
        logic [31:0]        r;
        logic [31:0]        b;
        logic [31:0]        row;
        logic [31:0]        col;
        logic [BG_BITS-1:0] bg;
        logic [BA_BITS-1:0] ba;
        @(negedge clk);
        take_bits(idle_bits, r);
        req_valid = (r == 0);
        if (r == 0) begin
            take_bits(4, b);
            take_bits(row_bits, row);
            take_bits(1, r);
            req_write = r[0];
            bg        = (bank < 0) ? b[3:2] : 2'(bank >> 2);
            ba        = (bank < 0) ? b[1:0] : 2'(bank);
            take_bits(COL_BITS, col);
            // row, bank group, bank and column from the top bit down
            req_addr.flat = {row[ROW_BITS-1:0], bg, ba, col[COL_BITS-1:0]};
            take_bits(DATA_BITS, r);
            req_data = r[DATA_BITS-1:0];
            req_idx  = next_idx;
            next_idx++;
            sent++;
        end
    endtask

    task automatic drain();
        @(negedge clk);
        req_valid = 1'b0;
        while (accepted != issued || cmd_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        int now;
        drain();
        now = chk_errs + tb_errs;
        tests++;
        if (now != err_mark) begin
            failed++;
        end
        $display("test %-12s %s  errors %0d  commands %0d", name,
                 (now == err_mark) ? "ok" : "failed", now - err_mark, issued);
        err_mark = now;
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_data  = '0;
        req_idx   = '0;
        next_idx  = '0;
        lfsr      = 16'd41482;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (200) drive_cycle(-1, 16, 2);
        finish_test("addr_order");

        drive_cycle(9, 16, 0);
        @(negedge clk);
        req_valid = 1'b0;
        @(negedge clk);
        if (cmd_valid !== 1'b1) begin
            tb_errs++;
            $display("ERR %0t cmd_valid_o expected 1 got %b", $time, cmd_valid);
        end
        finish_test("latency");

        for (int i = 0; i < 32; i++) begin
            drive_cycle((i % 4) * 4 + (i / 4) % 4, 16, 0);
        end
        finish_test("round_robin");

        repeat (3 * QUEUE_DEPTH) drive_cycle(6, 16, 0);
        finish_test("overflow");

        // two row bits give both row hits and row changes
        repeat (40) drive_cycle(13, 2, 0);
        finish_test("activate");

        repeat (300) drive_cycle(-1, 3, 1);
        drain();
        if (cmd_seen != accepted || sent != accepted + dropped) begin
            tb_errs++;
            $display("drain: %0d sent, %0d accepted, %0d dropped, but %0d commands seen",
                     sent, accepted, dropped, cmd_seen);
        end
        finish_test("drain");

        $display("tests %0d  failed %0d  errors %0d  requests %0d  commands %0d  drops %0d",
                 tests, failed, chk_errs + tb_errs, sent, issued, dropped);
        if (failed == 0 && chk_errs + tb_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
logic/ddr_geom_pkg.sv
logic/ddr_req_pkg.sv
logic/bank_queue_array.sv
logic/bank_scheduler.sv
logic/data_path.sv
logic/cmd_output_stage.sv
logic/ddr_sched_top.sv
tb/sched_checker.sv
tb/tb_ddr_sched.sv

/* Bender.yml */
package:
  name: ddr_sched

sources:
  - logic/ddr_geom_pkg.sv
  - logic/ddr_req_pkg.sv
  - logic/bank_queue_array.sv
  - logic/bank_scheduler.sv
  - logic/data_path.sv
  - logic/cmd_output_stage.sv
  - logic/ddr_sched_top.sv
  - target: test
    files:
      - tb/sched_checker.sv
      - tb/tb_ddr_sched.sv
